//--- hdl/rv_pipe_defs.svh
`ifndef RV_PIPE_DEFS_SVH
`define RV_PIPE_DEFS_SVH

// Register address and data widths for RV32I.
`define RV_REG_W 5
`define RV_XLEN  32

// ======================================================================
// Major opcodes
// ======================================================================
`define OP_BUBBLE 7'b0000000
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011
`define OP_BRANCH 7'b1100011
`define OP_JAL    7'b1101111
`define OP_JALR   7'b1100111
`define OP_LUI    7'b0110111
`define OP_AUIPC  7'b0010111
`define OP_OPIMM  7'b0010011
`define OP_OP     7'b0110011

`endif

//--- hdl/rv_pipe_pkg.sv
`include "rv_pipe_defs.svh"

package rv_pipe_pkg;

    typedef logic [`RV_REG_W-1:0] reg_addr_t;
    typedef logic [6:0]           opcode_t;
    typedef logic [`RV_XLEN-1:0]  word_t;

    // Source of an execute stage operand.
    typedef enum logic [1:0] {
        FWD_NONE = 2'b00,
        FWD_MEM  = 2'b01,
        FWD_WB   = 2'b10
    } fwd_sel_t;

    // ==================================================================
    // Per-stage instruction metadata
    // ==================================================================
    // All zero is a bubble.
    typedef struct packed {
        opcode_t   opcode;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        logic      uses_rs1;
        logic      uses_rs2;
        logic      writes_rd;
    } instr_info_t;

    // Resolution of the branch or jump now in execute.
    typedef struct packed {
        logic  branch;
        logic  jump;
        logic  taken;
        logic  prediction_made;
        logic  predicted_taken;
        word_t btb_target;
        word_t pc_target;
        word_t pc_plus4;
    } branch_res_t;

endpackage

//--- hdl/instr_field_decode.sv
`timescale 1ns/1ns
`include "rv_pipe_defs.svh"

module instr_field_decode (
    input  rv_pipe_pkg::word_t       instr,
    input  logic                     instr_valid,
    output rv_pipe_pkg::instr_info_t info
);

    always_comb begin
        info = '0;
        if (instr_valid) begin
            info.opcode = instr[6:0];
            info.rd     = instr[11:7];
            info.rs1    = instr[19:15];
            info.rs2    = instr[24:20];

            // Source register use by opcode class.
            case (instr[6:0])
                `OP_LUI,
                `OP_AUIPC,
                `OP_JAL: begin
                    info.uses_rs1 = 1'b0;
                    info.uses_rs2 = 1'b0;
                end
                `OP_JALR,
                `OP_LOAD,
                `OP_OPIMM: begin
                    info.uses_rs1 = 1'b1;
                    info.uses_rs2 = 1'b0;
                end
                `OP_STORE,
                `OP_BRANCH,
                `OP_OP: begin
                    info.uses_rs1 = 1'b1;
                    info.uses_rs2 = 1'b1;
                end
                default: begin
                    // Unknown or zero opcode reads nothing.
                    info.uses_rs1 = 1'b0;
                    info.uses_rs2 = 1'b0;
                end
            endcase

            // Stores and branches have no destination, x0 is never written.
            info.writes_rd = (instr[6:0] != `OP_STORE) &&
                             (instr[6:0] != `OP_BRANCH) &&
                             (instr[11:7] != '0);
        end
    end

endmodule

//--- hdl/stage_tracker.sv
`timescale 1ns/1ns

module stage_tracker (
    input  logic                     clk,
    input  logic                     reset,

    input  rv_pipe_pkg::instr_info_t dec_info,

    input  logic                     f_d_en,
    input  logic                     d_e_en,
    input  logic                     no_op,
    input  logic                     flush,

    output rv_pipe_pkg::instr_info_t d_info,
    output rv_pipe_pkg::instr_info_t e_info,
    output rv_pipe_pkg::instr_info_t m_info,
    output rv_pipe_pkg::instr_info_t w_info
);

    // Execute holds only for the divider, load-use and flush bubble it.
    logic e_hold;

    assign e_hold = !d_e_en && !no_op && !flush;

    // ==================================================================
    // Decode stage
    // ==================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            d_info <= '0;
        end else if (flush) begin
            d_info <= '0;
        end else if (f_d_en) begin
            d_info <= dec_info;
        end
    end

    // ==================================================================
    // Execute stage
    // ==================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            e_info <= '0;
        end else if (no_op || flush) begin
            e_info <= '0;
        end else if (d_e_en) begin
            e_info <= d_info;
        end
    end

    // ==================================================================
    // Memory and writeback stages
    // ==================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            m_info <= '0;
        end else if (e_hold) begin
            // Held execute instruction must not be issued twice.
            m_info <= '0;
        end else begin
            m_info <= e_info;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            w_info <= '0;
        end else begin
            w_info <= m_info;
        end
    end

    // A bubble never claims a source register on its way through.
    a_bubble_no_src : assert property (
        @(posedge clk) disable iff (reset)
        !(e_info.uses_rs1 && (e_info.opcode == '0))
    ) else $error("execute bubble with rs1 use set");

endmodule

//--- hdl/hazard_unit.sv
`timescale 1ns/1ns
`include "rv_pipe_defs.svh"

module hazard_unit (
    input  rv_pipe_pkg::instr_info_t d_info,
    input  rv_pipe_pkg::instr_info_t e_info,
    input  rv_pipe_pkg::instr_info_t m_info,
    input  rv_pipe_pkg::instr_info_t w_info,

    input  rv_pipe_pkg::branch_res_t ex_res,
    input  logic                     div_stall,

    output rv_pipe_pkg::fwd_sel_t    fwd_a,
    output rv_pipe_pkg::fwd_sel_t    fwd_b,

    output logic                     pc_en,
    output logic                     f_d_en,
    output logic                     d_e_en,
    output logic                     no_op,
    output logic                     pc_src,
    output logic                     flush,
    output rv_pipe_pkg::word_t       redirect_target
);

    import rv_pipe_pkg::*;

    logic load_use;
    logic mispredict;
    logic target_mismatch;

    // ==================================================================
    // Operand forwarding
    // ==================================================================
    // Memory wins over writeback, a load in memory has no data yet.
    function automatic fwd_sel_t fwd_select(
        input reg_addr_t   src,
        input logic        uses,
        input instr_info_t m,
        input instr_info_t w
    );
        fwd_sel_t sel;
        sel = FWD_NONE;
        if (uses && m.writes_rd && (m.rd == src) && (m.opcode != `OP_LOAD)) begin
            sel = FWD_MEM;
        end else if (uses && w.writes_rd && (w.rd == src)) begin
            sel = FWD_WB;
        end
        return sel;
    endfunction

    assign fwd_a = fwd_select(e_info.rs1, e_info.uses_rs1, m_info, w_info);
    assign fwd_b = fwd_select(e_info.rs2, e_info.uses_rs2, m_info, w_info);

    // Load in execute feeding a source of decode.
    assign load_use = (e_info.opcode == `OP_LOAD) &&
                      (((d_info.rs1 == e_info.rd) && d_info.uses_rs1) ||
                       ((d_info.rs2 == e_info.rd) && d_info.uses_rs2));

    // ==================================================================
    // Branch and jump resolution
    // ==================================================================
    assign target_mismatch = (ex_res.btb_target != ex_res.pc_target);

    always_comb begin
        mispredict = 1'b0;
        if (ex_res.branch) begin
            if (!ex_res.prediction_made) begin
                mispredict = ex_res.taken;
            end else if (ex_res.taken) begin
                mispredict = !ex_res.predicted_taken || target_mismatch;
            end else begin
                mispredict = ex_res.predicted_taken;
            end
        end else if (ex_res.jump) begin
            if (e_info.opcode == `OP_JALR) begin
                mispredict = 1'b1;
            end else if (ex_res.prediction_made && ex_res.predicted_taken) begin
                mispredict = target_mismatch;
            end else begin
                mispredict = 1'b1;
            end
        end
    end

    assign pc_src = mispredict;
    assign flush  = pc_src;

    assign redirect_target = (ex_res.jump || (ex_res.branch && ex_res.taken)) ?
                             ex_res.pc_target : ex_res.pc_plus4;

    // ==================================================================
    // Stage enables
    // ==================================================================
    always_comb begin
        if (mispredict) begin
            // Redirect overrides any stall, the stalled work is squashed.
            pc_en  = 1'b1;
            f_d_en = 1'b1;
            d_e_en = 1'b1;
            no_op  = 1'b0;
        end else begin
            pc_en  = !load_use && !div_stall;
            f_d_en = !load_use && !div_stall;
            d_e_en = !load_use && !div_stall;
            no_op  = load_use;
        end
    end

    always_comb begin
        a_flush_redirect : assert (!flush || pc_src)
            else $error("flush raised without a redirect");
        a_no_load_fwd : assert (!((fwd_a == FWD_MEM) && (m_info.opcode == `OP_LOAD)))
            else $error("operand A forwarded from a load in memory");
    end

endmodule

//--- hdl/pipeline_control.sv
`timescale 1ns/1ns

module pipeline_control (
    input  logic                     clk,
    input  logic                     reset,

    input  logic                     instr_valid,
    input  rv_pipe_pkg::word_t       instr,
    input  rv_pipe_pkg::branch_res_t ex_res,
    input  logic                     div_stall,

    output rv_pipe_pkg::fwd_sel_t    fwd_a,
    output rv_pipe_pkg::fwd_sel_t    fwd_b,
    output logic                     pc_en,
    output logic                     f_d_en,
    output logic                     no_op,
    output logic                     pc_src,
    output logic                     flush,
    output rv_pipe_pkg::word_t       redirect_target
);

    import rv_pipe_pkg::*;

    instr_info_t dec_info;
    instr_info_t d_info;
    instr_info_t e_info;
    instr_info_t m_info;
    instr_info_t w_info;
    logic        d_e_en;

    instr_field_decode instr_field_decode_i (
        .instr       (instr),
        .instr_valid (instr_valid),
        .info        (dec_info)
    );

    stage_tracker stage_tracker_i (
        .clk      (clk),
        .reset    (reset),
        .dec_info (dec_info),
        .f_d_en   (f_d_en),
        .d_e_en   (d_e_en),
        .no_op    (no_op),
        .flush    (flush),
        .d_info   (d_info),
        .e_info   (e_info),
        .m_info   (m_info),
        .w_info   (w_info)
    );

    hazard_unit hazard_unit_i (
        .d_info          (d_info),
        .e_info          (e_info),
        .m_info          (m_info),
        .w_info          (w_info),
        .ex_res          (ex_res),
        .div_stall       (div_stall),
        .fwd_a           (fwd_a),
        .fwd_b           (fwd_b),
        .pc_en           (pc_en),
        .f_d_en          (f_d_en),
        .d_e_en          (d_e_en),
        .no_op           (no_op),
        .pc_src          (pc_src),
        .flush           (flush),
        .redirect_target (redirect_target)
    );

endmodule

//--- verif/pipe_ref_model.svh
`ifndef PIPE_REF_MODEL_SVH
`define PIPE_REF_MODEL_SVH

// Model stage state and the outputs expected in the current cycle.
instr_info_t ref_d;
instr_info_t ref_e;
instr_info_t ref_m;
instr_info_t ref_w;
fwd_sel_t    exp_fwd_a;
fwd_sel_t    exp_fwd_b;
logic        exp_pc_en;
logic        exp_f_d_en;
logic        exp_d_e_en;
logic        exp_no_op;
logic        exp_pc_src;
word_t       exp_target;

function automatic instr_info_t decode_fields(input word_t w, input logic valid);
    instr_info_t r;
    r = '0;
    if (valid) begin
        r.opcode    = w[6:0];
        r.rd        = w[11:7];
        r.rs1       = w[19:15];
        r.rs2       = w[24:20];
        r.uses_rs1  = !(r.opcode inside {`OP_LUI, `OP_AUIPC, `OP_JAL});
        r.uses_rs2  = r.uses_rs1 && !(r.opcode inside {`OP_JALR, `OP_LOAD, `OP_OPIMM});
        r.writes_rd = !(r.opcode inside {`OP_STORE, `OP_BRANCH}) && (r.rd != '0);
    end
    return r;
endfunction

function automatic fwd_sel_t forward_source(input reg_addr_t src, input logic used);
    fwd_sel_t sel;
    sel = FWD_NONE;
    if (used && ref_w.writes_rd && (ref_w.rd == src))
        sel = FWD_WB;
    // The newer producer in memory overrides, unless it is a load.
    if (used && ref_m.writes_rd && (ref_m.rd == src) && (ref_m.opcode != `OP_LOAD))
        sel = FWD_MEM;
    return sel;
endfunction

task automatic predict_outputs();
    logic load_use;
    logic hit;
    logic mispredict;
    logic redirect_taken;
    load_use = (ref_e.opcode == `OP_LOAD) &&
               ((ref_d.uses_rs1 && (ref_d.rs1 == ref_e.rd)) ||
                (ref_d.uses_rs2 && (ref_d.rs2 == ref_e.rd)));
    hit = (ex_res.btb_target == ex_res.pc_target);
    mispredict = 1'b0;
    if (ex_res.branch) begin
        mispredict = ex_res.prediction_made ?
                     ((ex_res.taken != ex_res.predicted_taken) || (ex_res.taken && !hit)) :
                     ex_res.taken;
    end else if (ex_res.jump) begin
        mispredict = (ref_e.opcode == `OP_JALR) ||
                     !(ex_res.prediction_made && ex_res.predicted_taken && hit);
    end
    // Jumps and taken branches in execute go to their target.
    redirect_taken = (ref_e.opcode inside {`OP_JAL, `OP_JALR}) ||
                     ((ref_e.opcode == `OP_BRANCH) && ex_res.taken);
    exp_fwd_a  = forward_source(ref_e.rs1, ref_e.uses_rs1);
    exp_fwd_b  = forward_source(ref_e.rs2, ref_e.uses_rs2);
    exp_pc_src = mispredict;
    exp_no_op  = load_use && !mispredict;
    exp_pc_en  = mispredict || !(load_use || div_stall);
    exp_f_d_en = exp_pc_en;
    exp_d_e_en = exp_pc_en;
    exp_target = redirect_taken ? ex_res.pc_target : ex_res.pc_plus4;
endtask

task automatic advance_stages();
    logic e_hold;
    e_hold = !exp_d_e_en && !exp_no_op && !exp_pc_src;
    ref_w = ref_m;
    if (e_hold)
        ref_m = '0;
    else
        ref_m = ref_e;
    if (exp_no_op || exp_pc_src)
        ref_e = '0;
    else if (exp_d_e_en)
        ref_e = ref_d;
    if (exp_pc_src)
        ref_d = '0;
    else if (exp_f_d_en)
        ref_d = decode_fields(instr, instr_valid);
endtask

`endif

//--- verif/tb_pipeline_control.sv
`timescale 1ns/1ns
`include "rv_pipe_defs.svh"

module tb_pipeline_control;

    import rv_pipe_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int NUM_CYCLES = 2000;

    logic        clk;
    logic        reset;
    logic        instr_valid;
    word_t       instr;
    branch_res_t ex_res;
    logic        div_stall;
    fwd_sel_t    fwd_a;
    fwd_sel_t    fwd_b;
    logic        pc_en;
    logic        f_d_en;
    logic        no_op;
    logic        pc_src;
    logic        flush;
    word_t       redirect_target;

    integer      seed;
    int          errors;
    int          cycle;
    opcode_t     op_pool [8] = '{`OP_LOAD, `OP_OP, `OP_OPIMM, `OP_STORE,
                                 `OP_BRANCH, `OP_JAL, `OP_JALR, `OP_LUI};

    `include "pipe_ref_model.svh"

    pipeline_control pipeline_control_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ==================================================================
    // Stimulus generators
    // ==================================================================
    function automatic reg_addr_t draw_reg();
        logic [31:0] r;
        r = $random(seed);
        if (r[3:0] == 4'd0)
            return '0;
        if (r[3:0] == 4'd1)
            return r[8:4];
        // Mostly x1 to x4, so producers and consumers collide often.
        return reg_addr_t'(r[5:4]) + 5'd1;
    endfunction

    function automatic word_t draw_instr();
        logic [31:0] r;
        r = $random(seed);
        return {r[31:25], draw_reg(), draw_reg(), r[14:12], draw_reg(), op_pool[r[2:0]]};
    endfunction

    function automatic branch_res_t draw_branch_res(input opcode_t e_op);
        branch_res_t res;
        logic [31:0] r;
        r = $random(seed);
        res = '0;
        res.pc_target       = $random(seed);
        res.pc_plus4        = $random(seed);
        res.btb_target      = r[0] ? res.pc_target : $random(seed);
        res.prediction_made = r[1];
        res.predicted_taken = r[1] & r[2];
        res.branch          = (e_op == `OP_BRANCH);
        res.jump            = (e_op == `OP_JAL) || (e_op == `OP_JALR);
        res.taken           = res.jump || (res.branch && r[3]);
        return res;
    endfunction

    // ==================================================================
    // Checks
    // ==================================================================
    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
        if (got !== expected) begin
            $display("CHECK FAILED cycle %0d: %s = 0x%h, expected 0x%h",
                     cycle, name, got, expected);
            errors++;
        end
    endtask

    task automatic compare_outputs();
        compare_field("fwd_a", 32'(fwd_a), 32'(exp_fwd_a));
        compare_field("fwd_b", 32'(fwd_b), 32'(exp_fwd_b));
        compare_field("pc_en", 32'(pc_en), 32'(exp_pc_en));
        compare_field("f_d_en", 32'(f_d_en), 32'(exp_f_d_en));
        compare_field("no_op", 32'(no_op), 32'(exp_no_op));
        compare_field("pc_src", 32'(pc_src), 32'(exp_pc_src));
        compare_field("flush", 32'(flush), 32'(exp_pc_src));
        compare_field("redirect_target", redirect_target, exp_target);
    endtask

    initial begin
        logic [31:0] r;
        seed        = 95;
        errors      = 0;
        cycle       = 0;
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        ex_res      = '0;
        div_stall   = 1'b0;
        ref_d       = '0;
        ref_e       = '0;
        ref_m       = '0;
        ref_w       = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        #1;
        // Idle pipeline right after reset.
        compare_field("fwd_a", 32'(fwd_a), 32'(FWD_NONE));
        compare_field("fwd_b", 32'(fwd_b), 32'(FWD_NONE));
        compare_field("pc_en", 32'(pc_en), 32'd1);
        compare_field("f_d_en", 32'(f_d_en), 32'd1);
        compare_field("no_op", 32'(no_op), 32'd0);
        compare_field("pc_src", 32'(pc_src), 32'd0);
        compare_field("flush", 32'(flush), 32'd0);
        predict_outputs();
        advance_stages();
        for (cycle = 1; cycle <= NUM_CYCLES; cycle++) begin
            @(negedge clk);
            r = $random(seed);
            // A stalled fetch keeps presenting the same instruction.
            if (exp_f_d_en) begin
                instr       = draw_instr();
                instr_valid = (r[7:4] != 4'd0);
            end
            ex_res    = draw_branch_res(ref_e.opcode);
            div_stall = (r[15:8] < 8'd26);
            #1;
            predict_outputs();
            compare_outputs();
            advance_stages();
        end
        $display("Cycles run: %0d, errors: %0d", NUM_CYCLES, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        #((NUM_CYCLES + 10) * CLK_PERIOD + 100);
        $display("Timeout: the test loop did not complete in the expected time");
        $display("Verification failed");
        $finish;
    end

endmodule

//--- sources.f
+incdir+hdl
+incdir+verif
hdl/rv_pipe_pkg.sv
hdl/instr_field_decode.sv
hdl/stage_tracker.sv
hdl/hazard_unit.sv
hdl/pipeline_control.sv
verif/tb_pipeline_control.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sources.f --top-module tb_pipeline_control \
    -Mdir obj_dir -o tb_pipeline_control > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_pipeline_control > sim.log 2>&1
cat sim.log
grep -q "Verification failed" sim.log && exit 1
grep -q "Verification passed" sim.log && exit 0 || exit 1
